/* logic/rvPkg.sv */
`default_nettype none

package rvPkg;

    //////////////////////////////
    // Widths and counts
    //////////////////////////////

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int regCount = 1 << regAddrW;
    localparam int csrAddrW = 12;

    // Byte step from pc to the link address
    localparam logic [xlen-1:0] pcStep = 32'd4;

    //////////////////////////////
    // Machine-mode CSR map
    //////////////////////////////

    localparam logic [csrAddrW-1:0] addrMstatus  = 12'h300;
    localparam logic [csrAddrW-1:0] addrMtvec    = 12'h305;
    localparam logic [csrAddrW-1:0] addrMscratch = 12'h340;
    localparam logic [csrAddrW-1:0] addrMepc     = 12'h341;
    localparam logic [csrAddrW-1:0] addrMcause   = 12'h342;

    // Trap vector base out of reset
    localparam logic [xlen-1:0] mtvecReset = 32'h0000_0100;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Write-back source select
    typedef enum logic [1:0] {
        wbDmem   = 2'd0,
        wbAlu    = 2'd1,
        wbPcNext = 2'd2
    } wbSelT;

    // Same as funct3[1:0] of the Zicsr register forms
    typedef enum logic [1:0] {
        csrRw = 2'd1,
        csrRs = 2'd2,
        csrRc = 2'd3
    } csrOpT;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // One retiring instruction
    typedef struct packed {
        logic [regAddrW-1:0] rdAddr;
        logic                regWrite;
        wbSelT               wbSel;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     aluOut;
        logic [xlen-1:0]     dmemOut;
        logic                isCsr;
        csrOpT               csrOp;
        logic [csrAddrW-1:0] csrAddr;
        logic [xlen-1:0]     csrOperand;
        // rs1 index or zimm is zero
        logic                csrSrcZero;
    } wbReqT;

    typedef struct packed {
        logic                en;
        logic [regAddrW-1:0] addr;
        logic [xlen-1:0]     data;
    } regWriteT;

    typedef struct packed {
        logic                en;
        logic [csrAddrW-1:0] addr;
        csrOpT               op;
        logic [xlen-1:0]     operand;
    } csrWriteT;

    // Storage for the machine-mode CSR set
    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mscratch;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] mcause;
    } csrSetT;

    // Everything zero but the trap vector
    localparam csrSetT csrResetVal = '{mtvec: mtvecReset, default: '0};

endpackage

`default_nettype wire

/* logic/wbControl.sv */
`timescale 1ns/10ps
`default_nettype none

module wbControl import rvPkg::*; (
    input  wire logic            wbValid,
    input  wire wbReqT           wbReq,
    input  wire logic [xlen-1:0] csrRdata,
    output regWriteT             regWr,
    output logic [csrAddrW-1:0]  csrAddr,
    output csrWriteT             csrWr
);

    logic [xlen-1:0] pcNext;
    logic [xlen-1:0] wbData;
    logic            csrSetClr;
    logic            regWriteEn;

    //////////////////////////////
    // Write-back value
    //////////////////////////////

    // Link address for jal and jalr
    assign pcNext = wbReq.pc + pcStep;

    always_comb begin
        if (wbReq.isCsr) begin
            // Old CSR value goes to rd
            wbData = csrRdata;
        end else begin
            case (wbReq.wbSel)
                wbDmem: begin
                    wbData = wbReq.dmemOut;
                end
                wbAlu: begin
                    wbData = wbReq.aluOut;
                end
                wbPcNext: begin
                    wbData = pcNext;
                end
                default: begin
                    wbData = wbReq.aluOut;
                end
            endcase
        end
    end

    //////////////////////////////
    // Register write port
    //////////////////////////////

    // CSR ops write rd even when regWrite is low
    assign regWriteEn = wbReq.isCsr ? wbValid : (wbValid && wbReq.regWrite);

    always_comb begin
        regWr.en   = regWriteEn;
        regWr.addr = wbReq.rdAddr;
        regWr.data = wbData;
    end

    //////////////////////////////
    // CSR access
    //////////////////////////////

    assign csrAddr = wbReq.csrAddr;

    assign csrSetClr = (wbReq.csrOp == csrRs) || (wbReq.csrOp == csrRc);

    // Set or clear with a zero source is a pure read
    always_comb begin
        csrWr.en      = wbValid && wbReq.isCsr && !(csrSetClr && wbReq.csrSrcZero);
        csrWr.addr    = wbReq.csrAddr;
        csrWr.op      = wbReq.csrOp;
        csrWr.operand = wbReq.csrOperand;
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import rvPkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire regWriteT            regWr,
    input  wire logic [regAddrW-1:0] rs1Addr,
    input  wire logic [regAddrW-1:0] rs2Addr,
    output logic [xlen-1:0]          rdata1,
    output logic [xlen-1:0]          rdata2
);

    logic [xlen-1:0] regs [regCount];
    logic            wrLive;

    // Writes aimed at x0 are dropped here
    assign wrLive = regWr.en && (regWr.addr != '0);

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            regs[0] <= '0;
        end else if (wrLive) begin
            regs[regWr.addr] <= regWr.data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Zero for x0, then same-cycle bypass, then storage
    function automatic logic [xlen-1:0] readPort(
        input logic [regAddrW-1:0] addr,
        input logic [xlen-1:0]     stored,
        input regWriteT            wr
    );
        logic [xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr.en && (wr.addr == addr)) begin
            value = wr.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_comb begin
        rdata1 = readPort(rs1Addr, regs[rs1Addr], regWr);
    end

    always_comb begin
        rdata2 = readPort(rs2Addr, regs[rs2Addr], regWr);
    end

endmodule

`default_nettype wire

/* logic/csrFile.sv */
`timescale 1ns/10ps
`default_nettype none

module csrFile import rvPkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [csrAddrW-1:0] csrAddr,
    input  wire csrWriteT            csrWr,
    output logic [xlen-1:0]          csrRdata
);

    csrSetT          csrs;
    logic [xlen-1:0] wrOld;
    logic [xlen-1:0] wrNew;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    // Unmapped addresses read as zero
    function automatic logic [xlen-1:0] csrLookup(
        input logic [csrAddrW-1:0] addr,
        input csrSetT              set
    );
        logic [xlen-1:0] value;
        case (addr)
            addrMstatus: begin
                value = set.mstatus;
            end
            addrMtvec: begin
                value = set.mtvec;
            end
            addrMscratch: begin
                value = set.mscratch;
            end
            addrMepc: begin
                value = set.mepc;
            end
            addrMcause: begin
                value = set.mcause;
            end
            default: begin
                value = '0;
            end
        endcase
        return value;
    endfunction

    // Read port for the old value
    always_comb begin
        csrRdata = csrLookup(csrAddr, csrs);
    end

    //////////////////////////////
    // Read-modify-write
    //////////////////////////////

    always_comb begin
        wrOld = csrLookup(csrWr.addr, csrs);
        case (csrWr.op)
            csrRw: begin
                wrNew = csrWr.operand;
            end
            csrRs: begin
                wrNew = wrOld | csrWr.operand;
            end
            csrRc: begin
                wrNew = wrOld & ~csrWr.operand;
            end
            default: begin
                wrNew = wrOld;
            end
        endcase
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            csrs <= csrResetVal;
        end else if (csrWr.en) begin
            case (csrWr.addr)
                addrMstatus: begin
                    csrs.mstatus <= wrNew;
                end
                addrMtvec: begin
                    csrs.mtvec <= wrNew;
                end
                addrMscratch: begin
                    csrs.mscratch <= wrNew;
                end
                addrMepc: begin
                    csrs.mepc <= wrNew;
                end
                addrMcause: begin
                    csrs.mcause <= wrNew;
                end
                // Writes to unmapped CSRs vanish
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/wbStage.sv */
`timescale 1ns/10ps
`default_nettype none

module wbStage import rvPkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                wbValid,
    input  wire wbReqT               wbReq,
    input  wire logic [regAddrW-1:0] rs1Addr,
    input  wire logic [regAddrW-1:0] rs2Addr,
    output logic [xlen-1:0]          rdata1,
    output logic [xlen-1:0]          rdata2
);

    regWriteT            regWr;
    csrWriteT            csrWr;
    logic [csrAddrW-1:0] csrAddr;
    logic [xlen-1:0]     csrRdata;

    //////////////////////////////
    // Decode and select
    //////////////////////////////

    wbControl uControl (
        .wbValid  (wbValid),
        .wbReq    (wbReq),
        .csrRdata (csrRdata),
        .regWr    (regWr),
        .csrAddr  (csrAddr),
        .csrWr    (csrWr)
    );

    //////////////////////////////
    // Integer registers
    //////////////////////////////

    regFile uRegFile (
        .clk     (clk),
        .rst     (rst),
        .regWr   (regWr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    //////////////////////////////
    // Machine CSRs
    //////////////////////////////

    csrFile uCsrFile (
        .clk      (clk),
        .rst      (rst),
        .csrAddr  (csrAddr),
        .csrWr    (csrWr),
        .csrRdata (csrRdata)
    );

endmodule

`default_nettype wire

/* sim/wbStageTb.sv */
`timescale 1ns/10ps
`default_nettype none

module wbStageTb import rvPkg::*; ();

    localparam int halfPeriod = 20;
    localparam int period     = 2 * halfPeriod;
    localparam int fieldCount = 18;
    localparam int memAddrW   = 11;
    localparam int memDepth   = 1 << memAddrW;
    localparam int maxLines   = memDepth / fieldCount;

    localparam logic [31:0] endMarker = 32'hff;

    // Column index within one golden line
    localparam int fTest     = 0;
    localparam int fValid    = 1;
    localparam int fRd       = 2;
    localparam int fRegWrite = 3;
    localparam int fSel      = 4;
    localparam int fPc       = 5;
    localparam int fAlu      = 6;
    localparam int fDmem     = 7;
    localparam int fIsCsr    = 8;
    localparam int fOp       = 9;
    localparam int fCsrAddr  = 10;
    localparam int fOperand  = 11;
    localparam int fSrcZero  = 12;
    localparam int fRs1      = 13;
    localparam int fRs2      = 14;
    localparam int fChk      = 15;
    localparam int fExp1     = 16;
    localparam int fExp2     = 17;

    logic                clk;
    logic                rst;
    logic                wbValid;
    wbReqT               wbReq;
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [xlen-1:0]     rdata1;
    logic [xlen-1:0]     rdata2;

    logic [31:0] golden [memDepth];
    int          lineCount;
    bit          loaded;
    int          errorCount;
    int          testErrors;
    int          testsRun;
    int          testsFailed;

    wbStage dut (
        .clk     (clk),
        .rst     (rst),
        .wbValid (wbValid),
        .wbReq   (wbReq),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    initial begin
        clk = 1'b0;
    end

    always #(halfPeriod) clk = ~clk;

    //////////////////////////////
    // Golden vector access
    //////////////////////////////

    function automatic logic [31:0] field(input int line, input int col);
        logic [memAddrW-1:0] addr;
        addr = memAddrW'(line * fieldCount + col);
        return golden[addr];
    endfunction

    // Drive one golden line onto the DUT inputs
    task automatic applyLine(input int line);
        wbValid          = 1'(field(line, fValid));
        wbReq.rdAddr     = regAddrW'(field(line, fRd));
        wbReq.regWrite   = 1'(field(line, fRegWrite));
        wbReq.wbSel      = wbSelT'(2'(field(line, fSel)));
        wbReq.pc         = field(line, fPc);
        wbReq.aluOut     = field(line, fAlu);
        wbReq.dmemOut    = field(line, fDmem);
        wbReq.isCsr      = 1'(field(line, fIsCsr));
        wbReq.csrOp      = csrOpT'(2'(field(line, fOp)));
        wbReq.csrAddr    = csrAddrW'(field(line, fCsrAddr));
        wbReq.csrOperand = field(line, fOperand);
        wbReq.csrSrcZero = 1'(field(line, fSrcZero));
        rs1Addr          = regAddrW'(field(line, fRs1));
        rs2Addr          = regAddrW'(field(line, fRs2));
    endtask

    //////////////////////////////
    // Checks and reporting
    //////////////////////////////

    task automatic checkPort(
        input int              testNum,
        input int              port,
        input logic [xlen-1:0] expected,
        input logic [xlen-1:0] got
    );
        assert (got === expected) else begin
            $display("ERROR @%0t: test %0d port rdata%0d expected %h got %h",
                     $time, testNum, port, expected, got);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic closeTest(input int testNum);
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0d passed", testNum);
        end else begin
            $display("test %0d failed with %0d mismatches", testNum, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic runVectors();
        int curTest;
        int line;
        curTest = int'(field(0, fTest));
        for (line = 0; line < lineCount; line++) begin
            if (line > 0) begin
                @(negedge clk);
            end
            if (int'(field(line, fTest)) != curTest) begin
                closeTest(curTest);
                curTest = int'(field(line, fTest));
            end
            applyLine(line);
            // Just ahead of the rising edge that commits the write
            #(halfPeriod - 1);
            if (field(line, fChk) != 32'd0) begin
                checkPort(curTest, 1, field(line, fExp1), rdata1);
                checkPort(curTest, 2, field(line, fExp2), rdata2);
            end
        end
        closeTest(curTest);
        @(negedge clk);
        wbValid = 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst         = 1'b1;
        wbValid     = 1'b0;
        wbReq       = '0;
        rs1Addr     = '0;
        rs2Addr     = '0;
        errorCount  = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        lineCount   = 0;
        loaded      = 1'b0;

        $readmemh("sim/wbGolden.txt", golden);
        while (lineCount < maxLines && field(lineCount, fTest) !== endMarker) begin
            lineCount++;
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (lineCount == 0 || lineCount == maxLines) begin
            $display("golden file is empty or has no end marker");
            errorCount++;
        end else begin
            runVectors();
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget of one clock per vector plus reset and drain
    initial begin
        wait (loaded);
        #((lineCount + 10) * period);
        $display("timeout: golden vectors did not finish");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/wbGolden.txt */
// test valid rd regWrite wbSel pc aluOut dmemOut isCsr csrOp csrAddr csrOperand csrSrcZero
// rs1Addr rs2Addr checkEnable expRdata1 expRdata2, test ff ends the vectors
// test 1 write-back source select
01 1 01 1 0 00001000 aaaaaaaa 11112222 0 0 000 00000000 0 00 00 0 00000000 00000000
01 1 02 1 1 00001004 33334444 deadbeef 0 0 000 00000000 0 01 00 1 11112222 00000000
01 1 03 1 2 00001ffc 00000bad 00000bad 0 0 000 00000000 0 01 02 1 11112222 33334444
01 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 03 02 1 00002000 33334444
01 1 04 1 2 7ffffffc 0000beef 0000beef 0 0 000 00000000 0 03 01 1 00002000 11112222
01 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 04 03 1 80000000 00002000
// test 2 x0 and write gating
02 1 00 1 1 00000000 12345678 00000000 0 0 000 00000000 0 00 00 1 00000000 00000000
02 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 00 01 1 00000000 11112222
02 1 01 0 1 00000000 cafef00d 00000000 0 0 000 00000000 0 01 01 1 11112222 11112222
02 0 02 1 1 00000000 0badf00d 00000000 0 0 000 00000000 0 02 02 1 33334444 33334444
02 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 01 02 1 11112222 33334444
// test 3 same-cycle bypass
03 1 05 1 1 00000000 5a5a5a5a 00000000 0 0 000 00000000 0 05 05 1 5a5a5a5a 5a5a5a5a
03 1 05 1 0 00000000 00000000 a5a5a5a5 0 0 000 00000000 0 05 04 1 a5a5a5a5 80000000
03 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 05 05 1 a5a5a5a5 a5a5a5a5
03 1 06 1 1 00000000 00000066 00000000 0 0 000 00000000 0 06 05 1 00000066 a5a5a5a5
// test 4 CSR reset values, unknown address, rd of x0
04 1 0c 0 0 00000000 77777777 88888888 1 2 305 00000000 1 0c 0c 1 00000100 00000100
04 1 0d 0 0 00000000 77777777 88888888 1 2 300 00000000 1 0d 0c 1 00000000 00000100
04 1 0e 0 0 00000000 77777777 88888888 1 2 341 00000000 1 0e 0d 1 00000000 00000000
04 1 0f 0 0 00000000 77777777 88888888 1 2 342 00000000 1 0f 0e 1 00000000 00000000
04 1 10 0 0 00000000 77777777 88888888 1 2 340 00000000 1 10 0c 1 00000000 00000100
04 1 11 0 0 00000000 77777777 88888888 1 1 7c0 12345678 0 11 11 1 00000000 00000000
04 1 12 0 0 00000000 77777777 88888888 1 2 7c0 00000000 1 12 11 1 00000000 00000000
04 1 00 0 0 00000000 77777777 88888888 1 1 341 00000abc 0 00 0e 1 00000000 00000000
04 1 13 0 0 00000000 77777777 88888888 1 2 341 00000000 1 13 00 1 00000abc 00000000
// test 5 CSR read-modify-write on mscratch and mtvec
05 1 07 0 0 00000000 77777777 88888888 1 1 340 f0f0f0f0 0 07 07 1 00000000 00000000
05 1 08 0 0 00000000 77777777 88888888 1 2 340 0000000f 0 08 07 1 f0f0f0f0 00000000
05 1 09 0 0 00000000 77777777 88888888 1 3 340 000000f0 0 09 08 1 f0f0f0ff f0f0f0f0
05 1 0a 0 0 00000000 77777777 88888888 1 2 340 ffffffff 1 0a 09 1 f0f0f00f f0f0f0ff
05 1 0b 0 0 00000000 77777777 88888888 1 3 340 ffffffff 1 0b 0a 1 f0f0f00f f0f0f00f
05 1 14 0 0 00000000 77777777 88888888 1 2 305 00000003 0 14 14 1 00000100 00000100
05 1 15 0 0 00000000 77777777 88888888 1 3 305 00000001 0 15 14 1 00000103 00000100
05 1 16 0 0 00000000 77777777 88888888 1 1 305 80000000 0 16 15 1 00000102 00000103
05 1 17 0 0 00000000 77777777 88888888 1 3 305 ffffffff 1 17 16 1 80000000 00000102
05 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 17 08 1 80000000 f0f0f0f0
// end of vectors
ff 0 00 0 0 00000000 00000000 00000000 0 0 000 00000000 0 00 00 0 00000000 00000000

/* list.f */
logic/rvPkg.sv
logic/wbControl.sv
logic/regFile.sv
logic/csrFile.sv
logic/wbStage.sv
sim/wbStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the write-back testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module wbStageTb \
    -f list.f \
    -o wbStageSim

simOutput=$(./obj_dir/wbStageSim)
echo "$simOutput"

if grep -q "TEST PASSED" <<< "$simOutput"; then
    exit 0
fi
exit 1
